//--- filelist.f
ooo_const_pkg.sv
ooo_core_pkg.sv
iq_alloc.sv
rf_source_table.sv
rf_valid.sv
regstat_top.sv
tb_regstat.sv

//--- tb_regstat.sv
`timescale 1ns/1ps
/*
  testbench for regstat_top with QENTRIES 8 and LR0 56
  each table row is one clock cycle, inputs change on the falling edge
  a reference model of the queue, the producer table and the valid bits
  predicts ready, commit and rf_v values, a random tail drives completions only
*/
module tb_regstat
	import ooo_const_pkg::*, ooo_core_pkg::*;
();

	localparam int QENTRIES = 8;
	localparam int LR0 = 56;
	localparam int QW = $clog2(QENTRIES);
	localparam int PERIOD = 8;
	localparam int NRAND = 24;
	localparam int MARGIN = 40;
	localparam logic [31:0] NOP = '0;

	// one cycle of stimulus plus one register bit whose value the rules fix
	typedef struct packed {
		logic [3:0]    test;
		logic          f0v;
		logic [31:0]   f0;
		logic          f1v;
		logic [31:0]   f1;
		logic          cv;
		logic [QW-1:0] cid;
		logic          bm;
		logic [QW-1:0] mid;
		logic [5:0]    creg;
		logic          cval;
	} row_t;

	logic             clk;
	logic             rst;
	logic             fetch0_v;
	instr_t           fetch0_instr;
	logic             fetch1_v;
	instr_t           fetch1_instr;
	logic             complete_v;
	logic [QW-1:0]    complete_id;
	logic             branchmiss;
	logic [QW-1:0]    miss_id;
	logic             fetch0_ready;
	logic             fetch1_ready;
	logic [AREGS-1:0] rf_v;
	logic             commit0_v;
	regspec_t         commit0_tgt;
	logic [QW-1:0]    commit0_id;
	logic             commit1_v;
	regspec_t         commit1_tgt;
	logic [QW-1:0]    commit1_id;

	row_t rows[$];
	logic table_built;
	int   checks;
	int   errors;
	int   test_base;

	// reference model state
	logic [QENTRIES-1:0] m_v;
	logic [QENTRIES-1:0] m_done;
	logic [QENTRIES-1:0] m_wr;
	int                  m_tgt [QENTRIES];
	int                  m_head;
	int                  m_tail;
	int                  m_src [AREGS];
	logic [AREGS-1:0]    m_rfv;

	regstat_top #(.QENTRIES(QENTRIES), .LR0(LR0)) dut (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// ====================================================================
	// instruction words and their decode by the readiness rules
	// ====================================================================

	function automatic logic [31:0] alu_word(logic [5:0] op, int rt);
		return {op, 6'(rt), 6'd1, 14'd0};
	endfunction

	// a back branch gets a small negative displacement, a forward one a positive
	function automatic logic [31:0] branch_word(logic lk, logic back);
		return {6'(OP_BR), lk, back ? 25'h1fffffc : 25'd16};
	endfunction

	function automatic logic decodes_write(logic [31:0] w);
		if (w[31:26] == OP_ADD || w[31:26] == OP_ADDI)
			return 1'b1;
		return (w[31:26] == OP_BR) && w[25];
	endfunction

	function automatic int dest_reg(logic [31:0] w);
		return (w[31:26] == OP_BR) ? LR0 : int'(w[25:20]);
	endfunction

	function automatic logic branches_back(logic [31:0] w);
		return (w[31:26] == OP_BR) && w[24];
	endfunction

	task automatic check_val(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic add_row(input int t, input logic f0v, input logic [31:0] f0,
		input logic f1v, input logic [31:0] f1, input logic cv, input int cid,
		input logic bm, input int mid, input int creg, input logic cval);
		row_t r;
		r = {4'(t), f0v, f0, f1v, f1, cv, QW'(cid), bm, QW'(mid), 6'(creg), cval};
		rows.push_back(r);
	endtask

	// ====================================================================
	// one cycle, drive, predict, check, then step the model at the edge
	// ====================================================================

	task automatic apply_row(input row_t r);
		int               nfree;
		int               h1;
		int               mage;
		logic             rdy0;
		logic             rdy1;
		logic             e0;
		logic             e1;
		logic             c0;
		logic             c1;
		logic [QENTRIES-1:0] young;
		logic [AREGS-1:0] live;
		logic [AREGS-1:0] nxt;
		@(negedge clk);
		fetch0_v     = r.f0v;
		fetch0_instr = r.f0;
		fetch1_v     = r.f1v;
		fetch1_instr = r.f1;
		complete_v   = r.cv;
		complete_id  = r.cid;
		branchmiss   = r.bm;
		miss_id      = r.mid;
		#1;
		nfree = 0;
		for (int i = 0; i < QENTRIES; i++)
			if (!m_v[i])
				nfree++;
		h1   = (m_head + 1) % QENTRIES;
		rdy0 = (nfree > 0) && !r.bm;
		// slot 1 needs room for two and no back branch ahead of it
		rdy1 = (nfree >= 2) && !(r.f0v && branches_back(r.f0)) && !r.bm;
		e0   = r.f0v && rdy0;
		e1   = e0 && r.f1v && rdy1;
		c0   = m_v[m_head] && m_done[m_head];
		c1   = c0 && m_v[h1] && m_done[h1];
		check_val("fetch0_ready", fetch0_ready, rdy0);
		check_val("fetch1_ready", fetch1_ready, rdy1);
		check_val("commit0_v", commit0_v, c0);
		check_val("commit1_v", commit1_v, c1);
		if (c0)
			check_val("commit0_id", commit0_id, m_head);
		if (c0 && m_wr[m_head])
			check_val("commit0_tgt", commit0_tgt, m_tgt[m_head]);
		if (c1)
			check_val("commit1_id", commit1_id, h1);
		if (c1 && m_wr[h1])
			check_val("commit1_tgt", commit1_tgt, m_tgt[h1]);
		// survivors of a miss are the entries no younger than the missed branch
		mage  = (int'(r.mid) - m_head + QENTRIES) % QENTRIES;
		live  = '0;
		young = '0;
		for (int i = 0; i < QENTRIES; i++) begin
			young[i] = m_v[i] && (((i - m_head + QENTRIES) % QENTRIES) > mage);
			if (m_v[i] && !young[i] && m_wr[i])
				live[m_tgt[i]] = 1'b1;
		end
		@(posedge clk);
		nxt = m_rfv;
		if (r.bm)
			for (int n = 1; n < AREGS; n++)
				if (!m_rfv[n] && !live[n])
					nxt[n] = 1'b1;
		// a commit only counts while it is still the newest producer
		if (c0 && m_wr[m_head] && m_src[m_tgt[m_head]] == m_head)
			nxt[m_tgt[m_head]] = 1'b1;
		if (c1 && m_wr[h1] && m_src[m_tgt[h1]] == h1)
			nxt[m_tgt[h1]] = 1'b1;
		if (e0 && decodes_write(r.f0))
			nxt[dest_reg(r.f0)] = 1'b0;
		if (e1 && decodes_write(r.f1))
			nxt[dest_reg(r.f1)] = 1'b0;
		nxt[0] = 1'b1;
		m_rfv  = nxt;
		if (e0 && decodes_write(r.f0))
			m_src[dest_reg(r.f0)] = m_tail;
		if (e1 && decodes_write(r.f1))
			m_src[dest_reg(r.f1)] = (m_tail + 1) % QENTRIES;
		if (r.cv && m_v[r.cid])
			m_done[r.cid] = 1'b1;
		if (c0)
			m_v[m_head] = 1'b0;
		if (c1)
			m_v[h1] = 1'b0;
		if (r.bm) begin
			m_v    = m_v & ~young;
			m_tail = (int'(r.mid) + 1) % QENTRIES;
		end else begin
			if (e0) begin
				m_v[m_tail]    = 1'b1;
				m_done[m_tail] = 1'b0;
				m_wr[m_tail]   = decodes_write(r.f0);
				m_tgt[m_tail]  = dest_reg(r.f0);
			end
			if (e1) begin
				m_v[(m_tail + 1) % QENTRIES]    = 1'b1;
				m_done[(m_tail + 1) % QENTRIES] = 1'b0;
				m_wr[(m_tail + 1) % QENTRIES]   = decodes_write(r.f1);
				m_tgt[(m_tail + 1) % QENTRIES]  = dest_reg(r.f1);
			end
			m_tail = (m_tail + int'(e0) + int'(e1)) % QENTRIES;
		end
		m_head = (m_head + int'(c0) + int'(c1)) % QENTRIES;
		#2;
		check_val("rf_v", rf_v, m_rfv);
		check_val($sformatf("rf_v[%0d]", r.creg), rf_v[r.creg], r.cval);
	endtask

	// ====================================================================
	// stimulus table
	// ====================================================================

	task automatic build_table();
		add_row(1, 0, NOP, 0, NOP, 0, 0, 0, 0, 5, 1);
		// single writes, the zero register and a store
		add_row(2, 1, alu_word(OP_ADD, 5), 0, NOP, 0, 0, 0, 0, 5, 0);
		add_row(2, 1, alu_word(OP_ADD, 0), 1, alu_word(OP_STORE, 9), 0, 0, 0, 0, 0, 1);
		add_row(2, 0, NOP, 0, NOP, 0, 0, 0, 0, 9, 1);
		add_row(2, 0, NOP, 0, NOP, 1, 0, 0, 0, 9, 1);
		add_row(2, 0, NOP, 0, NOP, 1, 1, 0, 0, 5, 1);
		add_row(2, 0, NOP, 0, NOP, 1, 2, 0, 0, 5, 1);
		add_row(2, 0, NOP, 0, NOP, 0, 0, 0, 0, 0, 1);
		// two producers of r7 at ids 3 and 4, r8 at id 5 completes first
		add_row(3, 1, alu_word(OP_ADD, 7), 1, alu_word(OP_ADDI, 7), 0, 0, 0, 0, 7, 0);
		add_row(3, 1, alu_word(OP_ADD, 8), 0, NOP, 0, 0, 0, 0, 7, 0);
		add_row(3, 0, NOP, 0, NOP, 1, 5, 0, 0, 8, 0);
		add_row(3, 0, NOP, 0, NOP, 1, 3, 0, 0, 8, 0);
		add_row(3, 0, NOP, 0, NOP, 0, 0, 0, 0, 7, 0);
		add_row(3, 0, NOP, 0, NOP, 1, 4, 0, 0, 7, 0);
		add_row(3, 0, NOP, 0, NOP, 0, 0, 0, 0, 7, 1);
		add_row(3, 0, NOP, 0, NOP, 0, 0, 0, 0, 8, 1);
		// linking back branch at id 6 holds back slot 1, a forward branch does not
		add_row(4, 1, branch_word(1, 1), 1, alu_word(OP_ADD, 9), 0, 0, 0, 0, 56, 0);
		add_row(4, 1, alu_word(OP_ADD, 9), 0, NOP, 0, 0, 0, 0, 9, 0);
		add_row(4, 1, branch_word(0, 0), 1, alu_word(OP_ADD, 10), 0, 0, 0, 0, 10, 0);
		// the forward branch at id 0 misses, ids 1 to 3 are flushed
		add_row(5, 1, alu_word(OP_ADD, 11), 1, alu_word(OP_ADD, 12), 0, 0, 0, 0, 12, 0);
		add_row(5, 1, alu_word(OP_ADD, 13), 0, NOP, 0, 0, 1, 0, 10, 1);
		add_row(5, 0, NOP, 0, NOP, 0, 0, 0, 0, 11, 1);
		add_row(5, 0, NOP, 0, NOP, 0, 0, 0, 0, 12, 1);
		add_row(5, 0, NOP, 0, NOP, 0, 0, 0, 0, 9, 0);
		add_row(5, 0, NOP, 0, NOP, 1, 6, 0, 0, 56, 0);
		add_row(5, 0, NOP, 0, NOP, 1, 7, 0, 0, 56, 1);
		add_row(5, 0, NOP, 0, NOP, 1, 0, 0, 0, 9, 1);
		add_row(5, 0, NOP, 0, NOP, 0, 0, 0, 0, 9, 1);
		// fill all entries, refused slots must leave their targets valid
		add_row(6, 1, alu_word(OP_ADD, 20), 1, alu_word(OP_ADD, 21), 0, 0, 0, 0, 20, 0);
		add_row(6, 1, alu_word(OP_ADD, 22), 1, alu_word(OP_ADD, 23), 0, 0, 0, 0, 23, 0);
		add_row(6, 1, alu_word(OP_ADD, 24), 1, alu_word(OP_ADD, 25), 0, 0, 0, 0, 25, 0);
		add_row(6, 1, alu_word(OP_ADD, 26), 1, alu_word(OP_ADD, 27), 0, 0, 0, 0, 27, 0);
		add_row(6, 1, alu_word(OP_ADD, 30), 1, alu_word(OP_ADD, 31), 1, 1, 0, 0, 30, 1);
		add_row(6, 1, alu_word(OP_ADD, 30), 1, alu_word(OP_ADD, 31), 0, 0, 0, 0, 20, 1);
		add_row(6, 1, alu_word(OP_ADD, 30), 1, alu_word(OP_ADD, 31), 0, 0, 0, 0, 30, 0);
		add_row(6, 0, NOP, 0, NOP, 0, 0, 0, 0, 31, 1);
	endtask

	// the run limit follows from the number of rows and random cycles
	initial begin
		wait (table_built);
		#((rows.size() + NRAND + MARGIN) * PERIOD);
		$display("watchdog expired, the DUT run did not reach its end in time");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		row_t r;
		int   pending[$];
		void'($urandom(24));
		rst          = 1'b1;
		fetch0_v     = 1'b0;
		fetch0_instr = '0;
		fetch1_v     = 1'b0;
		fetch1_instr = '0;
		complete_v   = 1'b0;
		complete_id  = '0;
		branchmiss   = 1'b0;
		miss_id      = '0;
		checks       = 0;
		errors       = 0;
		test_base    = 0;
		table_built  = 1'b0;
		m_v          = '0;
		m_done       = '0;
		m_wr         = '0;
		m_head       = 0;
		m_tail       = 0;
		m_rfv        = '1;
		for (int i = 0; i < QENTRIES; i++)
			m_tgt[i] = 0;
		for (int n = 0; n < AREGS; n++)
			m_src[n] = 0;
		build_table();
		table_built = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int k = 0; k < rows.size(); k++) begin
			apply_row(rows[k]);
			if (k == rows.size() - 1 || rows[k + 1].test != rows[k].test) begin
				$display("test %0d finished with %0d errors", rows[k].test, errors - test_base);
				test_base = errors;
			end
		end
		// random completions among the entries the model holds as in flight
		for (int k = 0; k < NRAND; k++) begin
			pending.delete();
			for (int i = 0; i < QENTRIES; i++)
				if (m_v[i] && !m_done[i])
					pending.push_back(i);
			r      = '0;
			r.test = 4'd7;
			r.cval = 1'b1;
			if (pending.size() > 0 && ($urandom % 4) != 0) begin
				r.cv  = 1'b1;
				r.cid = QW'(pending[$urandom % pending.size()]);
			end
			apply_row(r);
		end
		$display("test 7 finished with %0d errors", errors - test_base);
		$display("%0d checks done, %0d errors", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- regstat_top.sv
`timescale 1ns/1ps
/*
  register readiness tracking at the rename and dispatch boundary
  QENTRIES must be a power of two, LR0 names the link register
*/
module regstat_top
	import ooo_const_pkg::*, ooo_core_pkg::*;
#(
	parameter int QENTRIES = 8,
	parameter int LR0 = 56,
	localparam int QW = $clog2(QENTRIES)
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             fetch0_v,
	input  instr_t           fetch0_instr,
	input  logic             fetch1_v,
	input  instr_t           fetch1_instr,
	input  logic             complete_v,
	input  logic [QW-1:0]    complete_id,
	input  logic             branchmiss,
	input  logic [QW-1:0]    miss_id,
	output logic             fetch0_ready,
	output logic             fetch1_ready,
	output logic [AREGS-1:0] rf_v,
	output logic             commit0_v,
	output regspec_t         commit0_tgt,
	output logic [QW-1:0]    commit0_id,
	output logic             commit1_v,
	output regspec_t         commit1_tgt,
	output logic [QW-1:0]    commit1_id
);

	// enqueue side from the queue
	logic                     enq0_v;
	regspec_t                 enq0_tgt;
	logic                     enq0_rfw;
	logic [QW-1:0]            enq0_id;
	logic                     enq1_v;
	regspec_t                 enq1_tgt;
	logic                     enq1_rfw;
	logic [QW-1:0]            enq1_id;
	logic                     enq_back_br_lk;
	// recovery and ownership
	logic [AREGS-1:0]         livetarget;
	logic [AREGS-1:0][QW-1:0] rf_source;

	iq_alloc #(.QENTRIES(QENTRIES), .LR0(LR0)) u_iq (
		.clk, .rst,
		.fetch0_v, .fetch0_instr, .fetch1_v, .fetch1_instr,
		.complete_v, .complete_id, .branchmiss, .miss_id,
		.fetch0_ready, .fetch1_ready,
		.enq0_v, .enq0_tgt, .enq0_rfw, .enq0_id,
		.enq1_v, .enq1_tgt, .enq1_rfw, .enq1_id, .enq_back_br_lk,
		.commit0_v, .commit0_tgt, .commit0_id,
		.commit1_v, .commit1_tgt, .commit1_id,
		.livetarget
	);

	rf_source_table #(.QENTRIES(QENTRIES)) u_src (
		.clk, .rst,
		.enq0_v, .enq0_rfw, .enq0_tgt, .enq0_id,
		.enq1_v, .enq1_rfw, .enq1_tgt, .enq1_id,
		.rf_source
	);

	rf_valid #(.QENTRIES(QENTRIES), .LR0(LR0)) u_valid (
		.clk, .rst, .branchmiss, .livetarget,
		.enq0_v, .enq0_rfw, .enq0_tgt,
		.enq1_v, .enq1_rfw, .enq1_tgt, .enq_back_br_lk,
		.commit0_v, .commit0_tgt, .commit0_id,
		.commit1_v, .commit1_tgt, .commit1_id,
		.rf_source, .rf_v
	);

endmodule

//--- rf_valid.sv
`timescale 1ns/1ps
/*
  per-register valid bits, cleared on enqueue and set on commit or miss recovery
  a commit sets its target only if it is still the newest producer
  the enqueue side expects no enqueue while branchmiss is high
*/
module rf_valid
	import ooo_const_pkg::*, ooo_core_pkg::*;
#(
	parameter int QENTRIES = 8,
	parameter int LR0 = 56,
	localparam int QW = $clog2(QENTRIES)
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      branchmiss,
	input  logic [AREGS-1:0]          livetarget,
	input  logic                      enq0_v,
	input  logic                      enq0_rfw,
	input  regspec_t                  enq0_tgt,
	input  logic                      enq1_v,
	input  logic                      enq1_rfw,
	input  regspec_t                  enq1_tgt,
	input  logic                      enq_back_br_lk,
	input  logic                      commit0_v,
	input  regspec_t                  commit0_tgt,
	input  logic [QW-1:0]             commit0_id,
	input  logic                      commit1_v,
	input  regspec_t                  commit1_tgt,
	input  logic [QW-1:0]             commit1_id,
	input  logic [AREGS-1:0][QW-1:0]  rf_source,
	output logic [AREGS-1:0]          rf_v
);

	logic [AREGS-1:0] rf_vr;
	logic             commit0_own;
	logic             commit1_own;

	// a committing entry still owns its target when the tag table agrees
	assign commit0_own = (rf_source[commit0_tgt] == commit0_id);
	assign commit1_own = (rf_source[commit1_tgt] == commit1_id);

	// ====================================================================
	// valid bit update, later statements override earlier ones
	// ====================================================================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rf_vr <= '1;
		end else begin
			// after a miss nothing younger will ever write a register
			// that no survivor targets, so those bits are free again
			if (branchmiss) begin
				for (int n = ZERO_REG + 1; n < AREGS; n++)
					if (rf_vr[n] == INV && !livetarget[n])
						rf_vr[n] <= VAL;
			end

			// an older producer that lost its tag leaves the bit alone
			if (commit0_v && commit0_own)
				rf_vr[commit0_tgt] <= VAL;
			if (commit1_v && commit1_own)
				rf_vr[commit1_tgt] <= VAL;

			// enqueue comes last, a fresh producer beats a commit to the same register
			if (!branchmiss) begin
				if (enq_back_br_lk) begin
					// slot 1 is blocked behind a back branch, only the link register moves
					rf_vr[LR0] <= INV;
				end else begin
					if (enq0_v && enq0_rfw)
						rf_vr[enq0_tgt] <= INV;
					// on a shared target slot 1 is the one that counts,
					// both clear the same bit so the order only matters for clarity
					if (enq1_v && enq1_rfw)
						rf_vr[enq1_tgt] <= INV;
				end
			end
		end
	end

	// an instruction that names r0 still clears the stored bit
	// and the output hides it
	always_comb begin
		rf_v           = rf_vr;
		rf_v[ZERO_REG] = VAL;
	end

endmodule

//--- rf_source_table.sv
`timescale 1ns/1ps
/*
  newest in-flight producer of each architectural register
  a tag is only meaningful while the register's valid bit is clear
*/
module rf_source_table
	import ooo_const_pkg::*, ooo_core_pkg::*;
#(
	parameter int QENTRIES = 8,
	localparam int QW = $clog2(QENTRIES)
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      enq0_v,
	input  logic                      enq0_rfw,
	input  regspec_t                  enq0_tgt,
	input  logic [QW-1:0]             enq0_id,
	input  logic                      enq1_v,
	input  logic                      enq1_rfw,
	input  regspec_t                  enq1_tgt,
	input  logic [QW-1:0]             enq1_id,
	output logic [AREGS-1:0][QW-1:0]  rf_source
);

	// ====================================================================
	// tag update on enqueue
	// ====================================================================

	// the tag moves on the same edge that clears the valid bit,
	// so a commit in that cycle still compares against the old owner
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rf_source <= '0;
		end else begin
			if (enq0_v && enq0_rfw)
				rf_source[enq0_tgt] <= enq0_id;
			// slot 1 is the younger instruction
			// its write is scheduled last and wins a shared target
			if (enq1_v && enq1_rfw)
				rf_source[enq1_tgt] <= enq1_id;
		end
	end

	// flushed producers are not scrubbed here
	// the valid tracker recovers those registers from livetarget instead,
	// and a later allocation of the same id overwrites the tag anyway

endmodule

//--- iq_alloc.sv
`timescale 1ns/1ps
/*
  instruction queue of QENTRIES entries, QENTRIES must be a power of two
  allocates up to two entries at the tail and commits up to two from the head
  miss_id must name a valid entry while branchmiss is high
  completions aimed at an empty entry are dropped
*/
module iq_alloc
	import ooo_const_pkg::*, ooo_core_pkg::*;
#(
	parameter int QENTRIES = 8,
	parameter int LR0 = 56,
	localparam int QW = $clog2(QENTRIES)
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             fetch0_v,
	input  instr_t           fetch0_instr,
	input  logic             fetch1_v,
	input  instr_t           fetch1_instr,
	input  logic             complete_v,
	input  logic [QW-1:0]    complete_id,
	input  logic             branchmiss,
	input  logic [QW-1:0]    miss_id,
	output logic             fetch0_ready,
	output logic             fetch1_ready,
	output logic             enq0_v,
	output regspec_t         enq0_tgt,
	output logic             enq0_rfw,
	output logic [QW-1:0]    enq0_id,
	output logic             enq1_v,
	output regspec_t         enq1_tgt,
	output logic             enq1_rfw,
	output logic [QW-1:0]    enq1_id,
	output logic             enq_back_br_lk,
	output logic             commit0_v,
	output regspec_t         commit0_tgt,
	output logic [QW-1:0]    commit0_id,
	output logic             commit1_v,
	output regspec_t         commit1_tgt,
	output logic [QW-1:0]    commit1_id,
	output logic [AREGS-1:0] livetarget
);

	logic [QENTRIES-1:0] iq_v;
	logic [QENTRIES-1:0] iq_done;
	regspec_t            iq_tgt [QENTRIES];
	logic [QW-1:0]       head;
	logic [QW-1:0]       head1;
	logic [QW-1:0]       tail;
	logic [QW:0]         n_free;
	logic [QW-1:0]       ent_age [QENTRIES];
	logic [QW-1:0]       miss_age;
	logic [QENTRIES-1:0] younger;
	logic                back_br0;

	// ====================================================================
	// fetch side, decode each offered word once
	// ====================================================================

	// the occupied entries form one ring segment from head to tail-1
	// so counting the free ones is enough to know the tail is usable
	always_comb begin
		n_free = '0;
		for (int i = 0; i < QENTRIES; i++)
			n_free = n_free + (QW+1)'(!iq_v[i]);
	end

	assign back_br0 = fetch0_v && fn_is_back_branch(fetch0_instr);

	// nothing enters while the queue is being cut back after a miss
	assign fetch0_ready = (n_free != '0) && !branchmiss;
	// a back branch in slot 0 ends the fetch group, slot 1 waits a cycle
	assign fetch1_ready = (n_free >= 2) && !back_br0 && !branchmiss;

	assign enq0_v = fetch0_v && fetch0_ready;
	// slot 1 never overtakes slot 0
	assign enq1_v = enq0_v && fetch1_v && fetch1_ready;

	assign enq0_rfw = fn_writes_reg(fetch0_instr);
	assign enq1_rfw = fn_writes_reg(fetch1_instr);

	// instructions without a destination carry the zero register
	// so a commit or a miss never touches a real register on their behalf
	assign enq0_tgt = enq0_rfw ? fn_target(fetch0_instr, regspec_t'(LR0)) : regspec_t'(ZERO_REG);
	assign enq1_tgt = enq1_rfw ? fn_target(fetch1_instr, regspec_t'(LR0)) : regspec_t'(ZERO_REG);

	assign enq0_id = tail;
	assign enq1_id = tail + 1'b1;

	assign enq_back_br_lk = enq0_v && back_br0 && fetch0_instr.br.lk;

	// ====================================================================
	// in-order commit from the head
	// ====================================================================

	assign head1 = head + 1'b1;

	assign commit0_v   = iq_v[head] && iq_done[head];
	// the second commit only rides along with the first
	assign commit1_v   = commit0_v && iq_v[head1] && iq_done[head1];
	assign commit0_tgt = iq_tgt[head];
	assign commit0_id  = head;
	assign commit1_tgt = iq_tgt[head1];
	assign commit1_id  = head1;

	// ====================================================================
	// branch miss, age relative to the head decides who survives
	// ====================================================================

	assign miss_age = miss_id - head;

	always_comb begin
		livetarget = '0;
		for (int i = 0; i < QENTRIES; i++) begin
			ent_age[i] = QW'(i) - head;
			younger[i] = iq_v[i] && (ent_age[i] > miss_age);
			// survivors still owe a write to their target
			if (iq_v[i] && !younger[i])
				livetarget[iq_tgt[i]] = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			iq_v    <= '0;
			iq_done <= '0;
			head    <= '0;
			tail    <= '0;
		end else begin
			head <= head + QW'(commit0_v) + QW'(commit1_v);
			if (commit0_v)
				iq_v[head] <= 1'b0;
			if (commit1_v)
				iq_v[head1] <= 1'b0;
			if (complete_v && iq_v[complete_id])
				iq_done[complete_id] <= 1'b1;
			if (branchmiss) begin
				// the slot after the missed branch becomes the next allocation
				tail <= miss_id + 1'b1;
				for (int i = 0; i < QENTRIES; i++)
					if (younger[i])
						iq_v[i] <= 1'b0;
			end else begin
				tail <= tail + QW'(enq0_v) + QW'(enq1_v);
				if (enq0_v) begin
					iq_v[enq0_id]    <= 1'b1;
					iq_done[enq0_id] <= 1'b0;
				end
				if (enq1_v) begin
					iq_v[enq1_id]    <= 1'b1;
					iq_done[enq1_id] <= 1'b0;
				end
			end
		end
	end

	// target register of each entry, written when the entry is allocated
	always_ff @(posedge clk) begin
		if (enq0_v)
			iq_tgt[enq0_id] <= enq0_tgt;
		if (enq1_v)
			iq_tgt[enq1_id] <= enq1_tgt;
	end

endmodule

//--- ooo_core_pkg.sv
/*
  instruction word as seen at rename, decoded either as an alu or a branch format
  opcodes outside opcode_t decode as neither writing nor branching
  the link register number is a module parameter and is passed to fn_target
*/
package ooo_core_pkg;
	import ooo_const_pkg::*;

	typedef logic [REG_W-1:0] regspec_t;

	typedef enum logic [5:0] {
		OP_ADD   = 6'h01,
		OP_ADDI  = 6'h02,
		OP_STORE = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BR    = 6'h05
	} opcode_t;

	// alu format, rt is the destination and ra the first source
	typedef struct packed {
		opcode_t     opcode;
		regspec_t    rt;
		regspec_t    ra;
		logic [13:0] imm;
	} alu_fmt_t;

	// branch format, a set lk bit makes the branch write the link register
	typedef struct packed {
		opcode_t            opcode;
		logic               lk;
		logic signed [24:0] disp;
	} br_fmt_t;

	// both views overlay the same 32 bits and share the opcode field
	typedef union packed {
		alu_fmt_t alu;
		br_fmt_t  br;
	} instr_t;

	function automatic logic fn_writes_reg(instr_t ins);
		case (ins.alu.opcode)
			OP_ADD, OP_ADDI: return 1'b1;
			OP_BR:           return ins.br.lk;
			default:         return 1'b0;
		endcase
	endfunction

	// only a branch can reach here with a link target, anything else names rt
	function automatic regspec_t fn_target(instr_t ins, regspec_t lr0);
		if (ins.br.opcode == OP_BR)
			return lr0;
		return ins.alu.rt;
	endfunction

	// a negative displacement is a loop back edge, the sign bit says it all
	function automatic logic fn_is_back_branch(instr_t ins);
		return (ins.br.opcode == OP_BR) && ins.br.disp[24];
	endfunction

endpackage

//--- ooo_const_pkg.sv
/*
  generic constants for the register readiness logic
  register 0 is hardwired, so its valid bit always reads as set
*/
package ooo_const_pkg;

	// polarity of a per-register valid bit
	localparam logic VAL = 1'b1;
	localparam logic INV = 1'b0;

	// architectural register file size and the width of a register number
	localparam int AREGS = 64;
	localparam int REG_W = 6;

	// the hardwired zero register is never tracked
	// non-writing instructions carry it as a harmless target
	localparam int ZERO_REG = 0;

endpackage
